// ==== files.f ====
+incdir+rtl
rtl/romchk_pkg.sv
rtl/romchk_stream_if.sv
rtl/romchk_counter.sv
rtl/romchk_fsm.sv
rtl/romchk_hash.sv
rtl/romchk_compare.sv
rtl/romchk_bus.sv
rtl/romchk_top.sv
dv/romchk_props.sv
dv/romchk_tb.sv

// ==== dv/romchk_cases.txt ====
# C base step seal bad_addr bad_xor good: word a = (base + step*a) ^ (a << 24), seal 1 puts
# the lane digest in the top words, then bad_xor flips bad_addr. B early we addr: bus access
C 12345678 9e3779b9 1 0 00000000 1
B 1 0 3
B 1 1 7
B 0 0 0
B 0 0 17
B 0 0 31
B 0 1 9
C 12345678 9e3779b9 1 30 00010000 0
B 0 0 30
B 0 0 28
C 12345678 9e3779b9 1 5 80000001 0
B 1 0 5
B 0 0 5
B 0 1 5
C a5a5f00d 01000193 1 0 00000000 1
B 0 0 29
B 0 0 1
C a5a5f00d 01000193 1 27 00000004 0
B 0 0 27
B 0 0 26
C 0badc0de 2545f491 0 0 00000000 0
B 1 1 0
B 0 0 14

// ==== dv/romchk_tb.sv ====
// Testbench for the ROM checker: clock, reset, ROM model, case file runner and compare tasks
`timescale 1ns/1ps
`include "romchk_config.svh"

module romchk_tb;
  import romchk_pkg::*;

  localparam int Depth    = `ROMCHK_ROM_DEPTH;
  localparam int DigWords = `ROMCHK_DIGEST_WORDS;
  localparam int LowWords = Depth - DigWords;

  logic      clk_i;
  logic      rst_ni;
  logic      rom_req_o;
  rom_addr_t rom_addr_o;
  rom_word_t rom_data_i;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  rom_addr_t wb_adr_i;
  rom_word_t wb_dat_o;
  logic      wb_ack_o;
  logic      wb_err_o;
  logic      done_o;
  logic      good_o;
  digest_t   digest_o;

  // ROM contents of the running case
  rom_word_t image [Depth];

  // Case table, one entry per C line
  rom_word_t case_base [$];
  rom_word_t case_step [$];
  rom_word_t case_bad_xor [$];
  int        case_bad_addr [$];
  bit        case_seal [$];
  logic      case_good [$];
  // Bus accesses, each tied to the case above it
  int        acc_case [$];
  bit        acc_early [$];
  bit        acc_we [$];
  rom_addr_t acc_addr [$];

  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;

  romchk_top u_romchk_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rom_req_o  (rom_req_o),
    .rom_addr_o (rom_addr_o),
    .rom_data_i (rom_data_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .done_o     (done_o),
    .good_o     (good_o),
    .digest_o   (digest_o)
  );

  always #4 clk_i = ~clk_i;

  // ROM with one cycle of read latency
  always @(posedge clk_i) begin
    if (rom_req_o) begin
      rom_data_i <= image[rom_addr_o];
    end
  end

  // Hang guard over the whole run
  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      report_failure($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
    end
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input rom_word_t got, input rom_word_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_digest(input digest_t got, input digest_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_failure($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // Reference digest of the low words in the current image
  function automatic digest_t lane_digest();
    rom_word_t lanes [DigWords];
    rom_word_t cur;
    digest_t   dig;
    for (int i = 0; i < DigWords; i++) begin
      lanes[i] = rom_word_t'(i);
    end
    // Word n lands in lane n mod 4, rotated left by 7 and offset by n
    for (int n = 0; n < LowWords; n++) begin
      cur = lanes[n % DigWords];
      cur = ((cur << 7) | (cur >> 25)) ^ image[n];
      lanes[n % DigWords] = cur + rom_word_t'(n);
    end
    for (int i = 0; i < DigWords; i++) begin
      dig[i*32 +: 32] = lanes[i];
    end
    return dig;
  endfunction

  task automatic load_cases();
    int        fd;
    int        got;
    string     line;
    rom_word_t v_base;
    rom_word_t v_step;
    rom_word_t v_xor;
    int        v_seal;
    int        v_addr;
    int        v_good;
    int        v_we;
    fd = $fopen("dv/romchk_cases.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the case file dv/romchk_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      // Blank lines and column notes carry no case
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if (line.getc(0) == "C") begin
        got = $sscanf(line, "C %h %h %d %d %h %d", v_base, v_step, v_seal, v_addr, v_xor, v_good);
        if (got != 6) begin
          report_failure($sformatf("Case line could not be read: %s", line));
        end
        case_base.push_back(v_base);
        case_step.push_back(v_step);
        case_seal.push_back(v_seal != 0);
        case_bad_addr.push_back(v_addr);
        case_bad_xor.push_back(v_xor);
        case_good.push_back(v_good != 0);
      end else if (line.getc(0) == "B" && case_base.size() > 0) begin
        got = $sscanf(line, "B %d %d %d", v_seal, v_we, v_addr);
        if (got != 3) begin
          report_failure($sformatf("Bus line could not be read: %s", line));
        end
        acc_case.push_back(case_base.size() - 1);
        acc_early.push_back(v_seal != 0);
        acc_we.push_back(v_we != 0);
        acc_addr.push_back(rom_addr_t'(v_addr));
      end else begin
        report_failure($sformatf("Unknown line in the case file: %s", line));
      end
    end
    $fclose(fd);
  endtask

  task automatic build_image(input int c);
    digest_t seal_dig;
    // Fill word mixes the whole address into every bit lane
    for (int a = 0; a < Depth; a++) begin
      image[a] = (case_base[c] + case_step[c] * rom_word_t'(a)) ^ (rom_word_t'(a) << 24);
    end
    if (case_seal[c]) begin
      seal_dig = lane_digest();
      for (int w = 0; w < DigWords; w++) begin
        image[LowWords + w] = seal_dig[w*32 +: 32];
      end
    end
    image[case_bad_addr[c]] = image[case_bad_addr[c]] ^ case_bad_xor[c];
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    repeat (2) @(negedge clk_i);
    check_flag(done_o, 1'b0, "done_o in reset");
    check_flag(good_o, 1'b0, "good_o in reset");
    check_flag(rom_req_o, 1'b0, "rom_req_o in reset");
    check_flag(wb_ack_o, 1'b0, "wb_ack_o in reset");
    check_flag(wb_err_o, 1'b0, "wb_err_o in reset");
    rst_ni = 1'b1;
  endtask

  task automatic bus_access(input bit early, input bit we, input rom_addr_t addr);
    int        waited;
    logic      got_ack;
    logic      got_err;
    rom_word_t got_dat;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    waited   = 0;
    while (!(wb_ack_o || wb_err_o) && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    got_ack  = wb_ack_o;
    got_err  = wb_err_o;
    got_dat  = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!(got_ack || got_err)) begin
      report_failure($sformatf("Bus access to address %0d got neither ack nor err", addr));
    end
    // Before done the slave refuses in one cycle, afterwards it answers in two
    check_count(waited, early ? 1 : 2, "bus response latency");
    check_flag(got_err, early || we, "wb_err_o");
    check_flag(got_ack, !early && !we, "wb_ack_o");
    if (!early && !we) begin
      check_word(got_dat, image[addr], $sformatf("wb_dat_o at address %0d", addr));
    end
    repeat ($urandom_range(3, 0) + 1) @(negedge clk_i);
  endtask

  task automatic run_accesses(input int c, input bit early);
    for (int k = 0; k < acc_case.size(); k++) begin
      if (acc_case[k] == c && acc_early[k] == early) begin
        bus_access(acc_early[k], acc_we[k], acc_addr[k]);
      end
    end
  endtask

  task automatic wait_check_done();
    while (!done_o) begin
      check_flag(good_o, 1'b0, "good_o before done_o");
      @(negedge clk_i);
    end
  endtask

  initial begin
    int seed;
    seed       = 15;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    rom_data_i = '0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    void'($urandom(seed));
    load_cases();
    cycle_limit = 3 * case_base.size() * (Depth + 40);
    for (int c = 0; c < case_base.size(); c++) begin
      build_image(c);
      apply_reset();
      run_accesses(c, 1'b1);
      wait_check_done();
      check_flag(good_o, case_good[c], $sformatf("good_o of case %0d", c));
      check_digest(digest_o, lane_digest(), $sformatf("digest_o of case %0d", c));
      run_accesses(c, 1'b0);
    end
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dv/romchk_props.sv ====
// Concurrent assertions on the checker FSM stream, done flag and compare start, with their bind
`timescale 1ns/1ps

module romchk_props (
  input logic clk_i,
  input logic rst_ni,
  input logic stream_valid_i,
  input logic stream_last_i,
  input logic check_done_i,
  input logic cmp_start_i
);

  // Set by the first compare start after reset
  logic started_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
    end else if (cmp_start_i) begin
      started_q <= 1'b1;
    end
  end

  // The last low word is only ever flagged on a valid beat
  last_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_last_i |-> stream_valid_i)
    else $error("Stream last seen without stream valid");

  // Done is sticky until the next reset
  done_is_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_done_i |=> check_done_i)
    else $error("Check done fell before reset");

  // Only one compare start in a run
  start_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_start_i |-> !started_q)
    else $error("Compare started twice in one run");

  // Done can only follow a compare
  done_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(check_done_i) |-> started_q)
    else $error("Check done rose without a compare start");

endmodule

bind romchk_fsm romchk_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .stream_valid_i (stream.valid),
  .stream_last_i  (stream.last),
  .check_done_i   (check_done_o),
  .cmp_start_i    (cmp_start_o)
);

// ==== rtl/romchk_top.sv ====
// Top level of the ROM integrity checker with the counter, FSM, hash, compare and bus slave
`timescale 1ns/1ps

module romchk_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  output logic                  rom_req_o,
  output romchk_pkg::rom_addr_t rom_addr_o,
  input  romchk_pkg::rom_word_t rom_data_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  romchk_pkg::rom_addr_t wb_adr_i,
  output romchk_pkg::rom_word_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  output logic                  done_o,
  output logic                  good_o,
  output romchk_pkg::digest_t   digest_o
);
  import romchk_pkg::*;

  logic      cnt_read_req;
  rom_addr_t cnt_read_addr;
  rom_addr_t cnt_data_addr;
  logic      cnt_last_low;
  logic      cnt_done;
  logic      data_rdy;
  logic      hash_done;
  logic      cmp_start;
  logic      cmp_done;
  logic      check_done;
  digest_t   hash_digest;
  digest_t   exp_digest;

  // Low ROM words on their way into the hash
  romchk_stream_if u_stream ();

  romchk_counter u_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_rdy_i  (data_rdy),
    .read_req_o  (cnt_read_req),
    .read_addr_o (cnt_read_addr),
    .data_addr_o (cnt_data_addr),
    .last_low_o  (cnt_last_low),
    .done_o      (cnt_done)
  );

  romchk_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .read_req_i     (cnt_read_req),
    .read_addr_i    (cnt_read_addr),
    .data_addr_i    (cnt_data_addr),
    .last_low_i     (cnt_last_low),
    .counter_done_i (cnt_done),
    .data_rdy_o     (data_rdy),
    .rom_data_i     (rom_data_i),
    .stream         (u_stream.src),
    .hash_done_i    (hash_done),
    .cmp_done_i     (cmp_done),
    .cmp_start_o    (cmp_start),
    .exp_digest_o   (exp_digest),
    .check_done_o   (check_done)
  );

  romchk_hash u_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stream   (u_stream.snk),
    .digest_o (hash_digest),
    .done_o   (hash_done)
  );

  romchk_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (cmp_start),
    .digest_i     (hash_digest),
    .exp_digest_i (exp_digest),
    .done_o       (cmp_done),
    .good_o       (good_o)
  );

  romchk_bus u_bus (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .check_done_i (check_done),
    .chk_req_i    (cnt_read_req),
    .chk_addr_i   (cnt_read_addr),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .rom_req_o    (rom_req_o),
    .rom_addr_o   (rom_addr_o),
    .rom_data_i   (rom_data_i)
  );

  // Digest holds its final value once the FSM reaches Done
  assign done_o   = check_done;
  assign digest_o = hash_digest;

endmodule

// ==== rtl/romchk_bus.sv ====
// Wishbone classic slave for ROM reads after the check, and the ROM port mux
`timescale 1ns/1ps

module romchk_bus (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  check_done_i,
  input  logic                  chk_req_i,
  input  romchk_pkg::rom_addr_t chk_addr_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  romchk_pkg::rom_addr_t wb_adr_i,
  output romchk_pkg::rom_word_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  output logic                  rom_req_o,
  output romchk_pkg::rom_addr_t rom_addr_o,
  input  romchk_pkg::rom_word_t rom_data_i
);
  import romchk_pkg::*;

  rom_addr_t adr_q;
  logic      rd_q;
  logic      wr_q;
  logic      ack_q;
  logic      err_q;
  logic      start;

  // A new access is taken only once the previous one has fully ended
  assign start = wb_cyc_i & wb_stb_i & ~(rd_q | wr_q | ack_q | err_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q  <= 1'b0;
      wr_q  <= 1'b0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      rd_q  <= start & check_done_i & ~wb_we_i;
      wr_q  <= start & check_done_i & wb_we_i;
      // Reads ack after the ROM returns, writes fail on the same beat
      ack_q <= rd_q;
      // Anything before the check ends fails one cycle after stb
      err_q <= wr_q | (start & ~check_done_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= wb_adr_i;
    end
  end

  // Checker owns the ROM until done
  assign rom_req_o  = check_done_i ? rd_q : chk_req_i;
  assign rom_addr_o = check_done_i ? adr_q : chk_addr_i;

  assign wb_dat_o = ack_q ? rom_data_i : '0;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

endmodule

// ==== rtl/romchk_compare.sv ====
// Word-by-word comparison of the computed digest against the expected digest
`timescale 1ns/1ps
`include "romchk_config.svh"

module romchk_compare (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  romchk_pkg::digest_t digest_i,
  input  romchk_pkg::digest_t exp_digest_i,
  output logic                done_o,
  output logic                good_o
);
  import romchk_pkg::*;

  localparam digest_idx_t LastIdx = digest_idx_t'(`ROMCHK_DIGEST_WORDS - 1);

  logic        busy_q;
  logic        mismatch_q;
  logic        good_q;
  logic        word_diff;
  digest_idx_t idx_q;

  // One word per cycle, starting the cycle after start
  assign word_diff = digest_i[idx_q*$bits(rom_word_t) +: $bits(rom_word_t)] !=
                     exp_digest_i[idx_q*$bits(rom_word_t) +: $bits(rom_word_t)];
  assign done_o    = busy_q & (idx_q == LastIdx);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      mismatch_q <= 1'b0;
      good_q     <= 1'b0;
      idx_q      <= '0;
    end else if (start_i) begin
      busy_q     <= 1'b1;
      mismatch_q <= 1'b0;
      idx_q      <= '0;
    end else if (busy_q) begin
      mismatch_q <= mismatch_q | word_diff;
      idx_q      <= idx_q + 1'b1;
      // Verdict includes the final word
      if (done_o) begin
        busy_q <= 1'b0;
        good_q <= ~(mismatch_q | word_diff);
      end
    end
  end

  assign good_o = good_q;

endmodule

// ==== rtl/romchk_hash.sv ====
// Lane-mixing hash engine that absorbs the low ROM words and presents the digest
`timescale 1ns/1ps
`include "romchk_config.svh"

module romchk_hash (
  input  logic                clk_i,
  input  logic                rst_ni,
  romchk_stream_if.snk        stream,
  output romchk_pkg::digest_t digest_o,
  output logic                done_o
);
  import romchk_pkg::*;

  localparam int FinW = $clog2(`ROMCHK_HASH_FINISH) + 1;

  // One lane per digest word
  rom_word_t       lane_q [`ROMCHK_DIGEST_WORDS];
  rom_addr_t       word_cnt_q;
  logic            busy_q;
  logic [FinW-1:0] fin_cnt_q;
  logic            accept;
  digest_idx_t     lane_sel;
  rom_word_t       lane_rot;
  rom_word_t       lane_new;

  assign accept   = stream.valid & stream.ready;
  // Word n goes to lane n mod 4
  assign lane_sel = digest_idx_t'(word_cnt_q);
  assign lane_rot = {lane_q[lane_sel][24:0], lane_q[lane_sel][31:25]};
  assign lane_new = (lane_rot ^ stream.data) + rom_word_t'(word_cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `ROMCHK_DIGEST_WORDS; i++) begin
        lane_q[i] <= rom_word_t'(i);
      end
      word_cnt_q <= '0;
      busy_q     <= 1'b0;
      fin_cnt_q  <= '0;
    end else begin
      if (accept) begin
        lane_q[lane_sel] <= lane_new;
        word_cnt_q       <= word_cnt_q + 1'b1;
      end
      // Finish delay starts with the last word and ends with the done pulse
      if (accept && stream.last) begin
        busy_q    <= 1'b1;
        fin_cnt_q <= '0;
      end else if (done_o) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        fin_cnt_q <= fin_cnt_q + 1'b1;
      end
    end
  end

  assign stream.ready = ~busy_q;
  assign done_o       = busy_q & (fin_cnt_q == FinW'(`ROMCHK_HASH_FINISH - 1));

  always_comb begin
    for (int i = 0; i < `ROMCHK_DIGEST_WORDS; i++) begin
      digest_o[i*$bits(rom_word_t) +: $bits(rom_word_t)] = lane_q[i];
    end
  end

endmodule

// ==== rtl/romchk_fsm.sv ====
// Checker FSM: streams the low ROM words, snoops the expected digest and runs the compare
`timescale 1ns/1ps
`include "romchk_config.svh"

module romchk_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  read_req_i,
  input  romchk_pkg::rom_addr_t read_addr_i,
  input  romchk_pkg::rom_addr_t data_addr_i,
  input  logic                  last_low_i,
  input  logic                  counter_done_i,
  output logic                  data_rdy_o,
  input  romchk_pkg::rom_word_t rom_data_i,
  romchk_stream_if.src          stream,
  input  logic                  hash_done_i,
  input  logic                  cmp_done_i,
  output logic                  cmp_start_o,
  output romchk_pkg::digest_t   exp_digest_o,
  output logic                  check_done_o
);
  import romchk_pkg::*;

  // First address of the expected digest in the ROM
  localparam rom_addr_t TopStart = rom_addr_t'(`ROMCHK_ROM_DEPTH - `ROMCHK_DIGEST_WORDS);

  chk_state_e  state_d;
  chk_state_e  state_q;
  logic        valid_q;
  logic        cmp_start_q;
  logic        high_phase;
  logic        snoop;
  rom_addr_t   rel_addr;
  digest_idx_t snoop_idx;
  digest_t     exp_digest_q;

  // Linear path with one race: ROM reading against the hash finish
  always_comb begin
    state_d = state_q;
    case (state_q)
      ReadingLow: begin
        // The last low word has gone into the hash
        if (last_low_i && stream.valid && stream.ready) begin
          state_d = ReadingHigh;
        end
      end
      ReadingHigh: begin
        case ({hash_done_i, counter_done_i})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = HashAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end
      HashAhead: begin
        if (counter_done_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end
      Done: state_d = Done;
      default: state_d = ReadingLow;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ReadingLow;
      valid_q     <= 1'b0;
      cmp_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Every read of a low address yields a stream word on the next cycle
      valid_q     <= (valid_q & ~stream.ready) | (read_req_i & (read_addr_i < TopStart));
      // One pulse on the way into Checking
      cmp_start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  // While the top words arrive the hash plays no part, so the counter never waits
  assign high_phase = (state_q == ReadingHigh) || (state_q == HashAhead);
  assign data_rdy_o = stream.ready | high_phase;

  // Top words arrive on every cycle of the high phase until the counter is done
  assign snoop     = high_phase & ~counter_done_i;
  assign rel_addr  = data_addr_i - TopStart;
  assign snoop_idx = digest_idx_t'(rel_addr);

  always_ff @(posedge clk_i) begin
    if (snoop) begin
      exp_digest_q[snoop_idx*$bits(rom_word_t) +: $bits(rom_word_t)] <= rom_data_i;
    end
  end

  assign stream.valid = valid_q;
  assign stream.data  = rom_data_i;
  assign stream.last  = last_low_i;

  assign cmp_start_o  = cmp_start_q;
  assign exp_digest_o = exp_digest_q;
  assign check_done_o = (state_q == Done);

endmodule

// ==== rtl/romchk_counter.sv ====
// ROM address generator that reads every word once and tracks the word whose data arrives
`timescale 1ns/1ps
`include "romchk_config.svh"

module romchk_counter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  data_rdy_i,
  output logic                  read_req_o,
  output romchk_pkg::rom_addr_t read_addr_o,
  output romchk_pkg::rom_addr_t data_addr_o,
  output logic                  last_low_o,
  output logic                  done_o
);
  import romchk_pkg::*;

  localparam rom_addr_t TopAddr     = rom_addr_t'(`ROMCHK_ROM_DEPTH - 1);
  localparam rom_addr_t LastLowAddr =
      rom_addr_t'(`ROMCHK_ROM_DEPTH - `ROMCHK_DIGEST_WORDS - 1);

  // Next address to read and the address of the word on rom_data this cycle
  rom_addr_t read_addr_q;
  rom_addr_t data_addr_q;
  logic      req_q;
  logic      fin_q;
  logic      data_vld_q;
  logic      done_q;
  logic      go;
  logic      last_read;

  // Move on when the arriving word is taken, or when nothing is in flight yet
  assign go        = req_q & (data_rdy_i | ~data_vld_q);
  assign last_read = go & (read_addr_q == TopAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
      data_addr_q <= '0;
      req_q       <= 1'b0;
      fin_q       <= 1'b0;
      data_vld_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      // Requests start one cycle after reset and stop after the top address
      req_q      <= ~fin_q & ~last_read;
      fin_q      <= fin_q | last_read;
      data_vld_q <= go | (data_vld_q & ~data_rdy_i);
      // Done once the top word has been handed over, sticky until reset
      done_q     <= done_q | (data_vld_q & data_rdy_i & (data_addr_q == TopAddr));
      if (go) begin
        read_addr_q <= read_addr_q + 1'b1;
        data_addr_q <= read_addr_q;
      end
    end
  end

  // On a stall the held word is read again, so rom_data stays stable
  assign read_addr_o = go ? read_addr_q : data_addr_q;
  assign read_req_o  = req_q;
  assign data_addr_o = data_addr_q;
  assign last_low_o  = data_vld_q & (data_addr_q == LastLowAddr);
  assign done_o      = done_q;

endmodule

// ==== rtl/romchk_stream_if.sv ====
// Valid/ready word stream interface from the checker FSM to the hash engine
`timescale 1ns/1ps

interface romchk_stream_if;
  import romchk_pkg::*;

  // A word moves on any cycle where valid and ready are both high
  logic      valid;
  logic      ready;
  rom_word_t data;
  // Flags the highest word of the low part of the ROM
  logic      last;

  // Word source, driven by the FSM
  modport src (output valid, output data, output last, input ready);

  // Word sink, the hash engine
  modport snk (input valid, input data, input last, output ready);

endinterface

// ==== rtl/romchk_pkg.sv ====
// Package with the ROM checker word, address and index types and the FSM state enum
`include "romchk_config.svh"

package romchk_pkg;

  // One ROM word, also the width of a digest word
  typedef logic [31:0] rom_word_t;

  // Word address into the ROM
  typedef logic [$clog2(`ROMCHK_ROM_DEPTH)-1:0] rom_addr_t;

  // Selects one word of the digest
  typedef logic [$clog2(`ROMCHK_DIGEST_WORDS)-1:0] digest_idx_t;

  // Full digest, word 0 sits at the least significant end
  typedef logic [`ROMCHK_DIGEST_WORDS*32-1:0] digest_t;

  // Checker FSM states, the path only ever moves forward
  typedef enum logic [2:0] {
    ReadingLow, ReadingHigh, RomAhead, HashAhead, Checking, Done
  } chk_state_e;

endpackage

// ==== rtl/romchk_config.svh ====
// Configuration macros for the ROM checker: ROM depth, digest word count, hash finish delay
`ifndef ROMCHK_CONFIG_SVH
`define ROMCHK_CONFIG_SVH

// Number of 32-bit words in the ROM
`define ROMCHK_ROM_DEPTH 32

// Number of digest words, held in the top words of the ROM
`define ROMCHK_DIGEST_WORDS 4

// Cycles from the last accepted word to a valid digest
`define ROMCHK_HASH_FINISH 2

`endif
